//--- source/sysarr_settings.svh
`ifndef SYSARR_SETTINGS_SVH
`define SYSARR_SETTINGS_SVH

// array dimension, also rows and columns of one job
`define SYSARR_N 4
`define SYSARR_DATA_W 8
`define SYSARR_ACC_W 16

// jobs that can be in flight at the same time
`define SYSARR_SLOTS 3
`define SYSARR_FIFO_DEPTH (2 * `SYSARR_N)

`endif

//--- source/sysarr_pkg.sv
`include "sysarr_settings.svh"

package sysarr_pkg;

    typedef logic signed [`SYSARR_DATA_W-1:0] data_t;
    typedef logic signed [`SYSARR_ACC_W-1:0] acc_t;

    typedef data_t [`SYSARR_N-1:0] data_row_t; // element k sits at index k
    typedef acc_t [`SYSARR_N-1:0] acc_row_t;

    typedef logic [$clog2(`SYSARR_N)-1:0] row_idx_t;
    typedef logic [$clog2(3 * `SYSARR_N)-1:0] iter_t; // counts 0 to 3N-1 per job

    // one beat of the shared load bus, input wins over weight
    typedef struct packed {
        logic      input_en;
        logic      weight_en;
        row_idx_t  row;
        data_row_t data;
    } load_t;

    typedef struct packed {
        logic     partial_en;
        row_idx_t row;
        acc_row_t data;
    } ps_load_t;

    // strobes from the control unit to the datapath
    typedef struct packed {
        logic in_shift;
        logic ps_shift;
        logic mac_start;
        logic add_start;
    } cu_ctrl_t;

endpackage

//--- source/sysarr_row_fifo.sv
module sysarr_row_fifo #(
    parameter type payload_t = logic,
    parameter int DEPTH = 8
) (
    input  logic     clk,
    input  logic     nRST,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;

    assign empty = (count == '0);
    assign full = (count == DEPTH[$clog2(DEPTH+1)-1:0]);
    assign pop_data = mem[rd_ptr]; // head row is visible whenever the FIFO holds one

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // fifo_has_space upstream should keep these from ever firing
    assert property (@(posedge clk) disable iff (!nRST) push |-> !full || pop);
    assert property (@(posedge clk) disable iff (!nRST) pop |-> !empty);

endmodule

//--- source/sysarr_mac_array.sv
`include "sysarr_settings.svh"

module sysarr_mac_array (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 weight_en,
    input  sysarr_pkg::row_idx_t weight_row_idx,
    input  sysarr_pkg::data_row_t weight_data,
    input  logic                 mac_start,
    input  sysarr_pkg::data_row_t in_row,
    output logic                 mac_ready,
    output logic                 mac_valid,
    output sysarr_pkg::acc_row_t mac_row
);
    localparam int N = `SYSARR_N;

    sysarr_pkg::data_row_t weights [N]; // weights[k][c] is W[k][c]
    sysarr_pkg::data_t skew [1:N-1][0:N-2];
    sysarr_pkg::data_t stage_x [N];
    sysarr_pkg::acc_row_t stage_sum [N];
    sysarr_pkg::acc_row_t result_q;
    logic [N-1:0] stage_valid;
    logic result_valid_q;
    logic ready_q;

    // weights stay in place, only a load rewrites a row
    always_ff @(posedge clk) begin
        if (weight_en) begin
            weights[weight_row_idx] <= weight_data;
        end
    end

    // element k of a row is delayed k cycles so it meets its stage
    always_ff @(posedge clk) begin
        for (int k = 1; k < N; k++) begin
            skew[k][0] <= in_row[k];
            for (int j = 1; j < k; j++) begin
                skew[k][j] <= skew[k][j-1];
            end
        end
    end

    always_comb begin
        stage_x[0] = in_row[0];
        for (int k = 1; k < N; k++) begin
            stage_x[k] = skew[k][k-1];
        end
    end

    // stage k adds in[k] * W[k][c] to every running column sum
    always_ff @(posedge clk) begin
        for (int c = 0; c < N; c++) begin
            stage_sum[0][c] <= stage_x[0] * weights[0][c];
        end
        for (int k = 1; k < N; k++) begin
            for (int c = 0; c < N; c++) begin
                stage_sum[k][c] <= stage_sum[k-1][c] + stage_x[k] * weights[k][c];
            end
        end
        result_q <= stage_sum[N-1]; // realigned row, all columns leave together
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            stage_valid <= '0;
            result_valid_q <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            stage_valid <= {stage_valid[N-2:0], mac_start};
            result_valid_q <= stage_valid[N-1];
            ready_q <= !weight_en;
        end
    end

    // not ready while a weight row lands and in the cycle after it
    assign mac_ready = ready_q && !weight_en;
    assign mac_valid = result_valid_q;
    assign mac_row = result_q;

    assert property (@(posedge clk) disable iff (!nRST) mac_start |-> mac_ready);

endmodule

//--- source/sysarr_partial_adder.sv
`include "sysarr_settings.svh"

module sysarr_partial_adder (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 mac_valid,
    input  logic                 add_start,
    input  sysarr_pkg::acc_row_t mac_row,
    input  sysarr_pkg::acc_row_t ps_row,
    output logic                 sum_valid,
    output sysarr_pkg::acc_row_t sum_row
);
    localparam int HOLD = 2 * `SYSARR_N;
    localparam int PTR_W = $clog2(HOLD);

    // MAC rows wait here until their partial row is popped
    sysarr_pkg::acc_row_t hold [HOLD];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [$clog2(HOLD+1)-1:0] hold_cnt;
    sysarr_pkg::acc_row_t sum_next;

    always_comb begin
        for (int c = 0; c < `SYSARR_N; c++) begin
            sum_next[c] = hold[rd_ptr][c] + ps_row[c]; // wraps at the accumulator width
        end
    end

    always_ff @(posedge clk) begin
        if (mac_valid) begin
            hold[wr_ptr] <= mac_row;
        end
        if (add_start) begin
            sum_row <= sum_next;
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            hold_cnt <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= add_start;
            if (mac_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(HOLD - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (add_start) begin
                rd_ptr <= (rd_ptr == PTR_W'(HOLD - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (mac_valid && !add_start) begin
                hold_cnt <= hold_cnt + 1'b1;
            end else if (add_start && !mac_valid) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
        end
    end

    // the MAC row of a sum must already sit in the holding register
    assert property (@(posedge clk) disable iff (!nRST) add_start |-> hold_cnt != '0);

endmodule

//--- source/sysarr_control_unit.sv
`include "sysarr_settings.svh"

module sysarr_control_unit (
    input  logic                 clk,
    input  logic                 nRST,
    input  sysarr_pkg::load_t    load,
    input  sysarr_pkg::ps_load_t ps_load,
    input  logic                 mac_ready,
    output sysarr_pkg::cu_ctrl_t ctrl,
    output logic                 fifo_has_space
);
    localparam int N = `SYSARR_N;
    localparam int SLOTS = `SYSARR_SLOTS;

    sysarr_pkg::iter_t iteration [SLOTS];
    sysarr_pkg::iter_t nxt_iteration [SLOTS];
    logic [SLOTS-1:0] slot_full;
    logic [SLOTS-1:0] nxt_slot_full;

    logic [N-1:0] in_loaded; // rows of the job currently being written
    logic [N-1:0] nxt_in_loaded;
    logic [N-1:0] ps_loaded;
    logic [N-1:0] nxt_ps_loaded;
    logic in_all; // every input row of the job in its input phase is loaded
    logic nxt_in_all;
    logic [1:0] ps_all_cnt; // jobs whose partial rows are all loaded
    logic [1:0] nxt_ps_all_cnt;

    logic in_phase;
    logic ps_phase;
    sysarr_pkg::row_idx_t in_row;
    sysarr_pkg::row_idx_t ps_row;
    logic in_ok;
    logic ps_ok;
    logic step;
    logic start_job;
    logic claimed;
    logic in_last;
    logic ps_last;
    logic ps_pending; // partial strobe waits one cycle for its MAC row to reach the adder
    sysarr_pkg::cu_ctrl_t nxt_ctrl;

    // find the slot that waits for an input row and the one that waits for a partial row
    always_comb begin
        in_phase = 1'b0;
        ps_phase = 1'b0;
        in_row = '0;
        ps_row = '0;
        for (int s = 0; s < SLOTS; s++) begin
            if (slot_full[s] && !in_phase && iteration[s] < sysarr_pkg::iter_t'(N)) begin
                in_phase = 1'b1;
                in_row = sysarr_pkg::row_idx_t'(iteration[s]);
            end
            if (slot_full[s] && !ps_phase && iteration[s] > sysarr_pkg::iter_t'(N)
                    && iteration[s] <= sysarr_pkg::iter_t'(2 * N)) begin
                ps_phase = 1'b1;
                ps_row = sysarr_pkg::row_idx_t'(iteration[s] - sysarr_pkg::iter_t'(N + 1));
            end
        end
    end

    assign in_ok = in_loaded[in_row] || in_all;
    assign ps_ok = ps_loaded[ps_row] || (ps_all_cnt != 2'd0);
    assign in_last = in_phase && (in_row == sysarr_pkg::row_idx_t'(N - 1));
    assign ps_last = ps_phase && (ps_row == sysarr_pkg::row_idx_t'(N - 1));

    // all slots move together, a missing row holds every slot for that cycle
    assign step = (|slot_full) && mac_ready && (!in_phase || in_ok) && (!ps_phase || ps_ok);

    assign start_job = load.input_en && (load.row == '0);

    always_comb begin
        nxt_iteration = iteration;
        nxt_slot_full = slot_full;
        claimed = 1'b0;
        for (int s = 0; s < SLOTS; s++) begin
            if (slot_full[s] && step) begin
                if (iteration[s] == sysarr_pkg::iter_t'(3 * N - 1)) begin
                    nxt_iteration[s] = '0;
                    nxt_slot_full[s] = 1'b0;
                end else begin
                    nxt_iteration[s] = iteration[s] + 1'b1;
                end
            end
        end
        for (int s = 0; s < SLOTS; s++) begin
            if (start_job && !slot_full[s] && !claimed) begin // lowest free slot takes the job
                nxt_slot_full[s] = 1'b1;
                nxt_iteration[s] = '0;
                claimed = 1'b1;
            end
        end
    end

    always_comb begin
        nxt_in_loaded = in_loaded;
        nxt_ps_loaded = ps_loaded;
        nxt_in_all = in_all;
        nxt_ps_all_cnt = ps_all_cnt;
        if (step && in_last) begin
            nxt_in_all = 1'b0;
        end
        if (step && ps_last) begin
            nxt_ps_all_cnt = nxt_ps_all_cnt - 2'd1;
        end
        if (load.input_en) begin
            nxt_in_loaded[load.row] = 1'b1;
        end
        if (ps_load.partial_en) begin
            nxt_ps_loaded[ps_load.row] = 1'b1;
        end
        if (&nxt_in_loaded) begin
            nxt_in_all = 1'b1;
            nxt_in_loaded = '0;
        end
        if (&nxt_ps_loaded) begin
            nxt_ps_all_cnt = nxt_ps_all_cnt + 2'd1;
            nxt_ps_loaded = '0;
        end
    end

    always_comb begin
        nxt_ctrl = '0;
        nxt_ctrl.in_shift = step && in_phase;
        nxt_ctrl.mac_start = step && in_phase;
        nxt_ctrl.ps_shift = ps_pending;
        nxt_ctrl.add_start = ps_pending;
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            iteration <= '{default: '0};
            slot_full <= '0;
            in_loaded <= '0;
            ps_loaded <= '0;
            in_all <= 1'b0;
            ps_all_cnt <= '0;
            ps_pending <= 1'b0;
            ctrl <= '0;
        end else begin
            iteration <= nxt_iteration;
            slot_full <= nxt_slot_full;
            in_loaded <= nxt_in_loaded;
            ps_loaded <= nxt_ps_loaded;
            in_all <= nxt_in_all;
            ps_all_cnt <= nxt_ps_all_cnt;
            ps_pending <= step && ps_phase;
            ctrl <= nxt_ctrl;
        end
    end

    // a new job may start only once no slot still collects input or partial rows
    assign fifo_has_space = !in_phase && !ps_phase;

    // row 0 of a job needs room in the FIFOs and a free slot to track it
    assert property (@(posedge clk) disable iff (!nRST)
        start_job |-> fifo_has_space && !(&slot_full));

endmodule

//--- source/sysarr_top.sv
`include "sysarr_settings.svh"

module sysarr_top (
    input  logic                 clk,
    input  logic                 nRST,
    input  sysarr_pkg::load_t    load,
    input  sysarr_pkg::ps_load_t ps_load,
    output logic                 fifo_has_space,
    output logic                 out_valid,
    output sysarr_pkg::acc_row_t out_row
);
    sysarr_pkg::cu_ctrl_t ctrl;
    sysarr_pkg::data_row_t in_head;
    sysarr_pkg::acc_row_t ps_head;
    sysarr_pkg::acc_row_t mac_row;
    sysarr_pkg::acc_row_t sum_row;
    logic mac_ready;
    logic mac_valid;
    logic sum_valid;
    logic out_empty;

    sysarr_control_unit u_cu (
        .clk            (clk),
        .nRST           (nRST),
        .load           (load),
        .ps_load        (ps_load),
        .mac_ready      (mac_ready),
        .ctrl           (ctrl),
        .fifo_has_space (fifo_has_space)
    );

    sysarr_row_fifo #(
        .payload_t (sysarr_pkg::data_row_t),
        .DEPTH     (`SYSARR_FIFO_DEPTH)
    ) u_in_fifo (
        .clk       (clk),
        .nRST      (nRST),
        .push      (load.input_en),
        .push_data (load.data),
        .pop       (ctrl.in_shift),
        .pop_data  (in_head),
        .empty     (),
        .full      ()
    );

    sysarr_row_fifo #(
        .payload_t (sysarr_pkg::acc_row_t),
        .DEPTH     (`SYSARR_FIFO_DEPTH)
    ) u_ps_fifo (
        .clk       (clk),
        .nRST      (nRST),
        .push      (ps_load.partial_en),
        .push_data (ps_load.data),
        .pop       (ctrl.ps_shift),
        .pop_data  (ps_head),
        .empty     (),
        .full      ()
    );

    // a weight beat counts only when the same beat does not carry an input row
    sysarr_mac_array u_mac (
        .clk            (clk),
        .nRST           (nRST),
        .weight_en      (load.weight_en && !load.input_en),
        .weight_row_idx (load.row),
        .weight_data    (load.data),
        .mac_start      (ctrl.mac_start),
        .in_row         (in_head),
        .mac_ready      (mac_ready),
        .mac_valid      (mac_valid),
        .mac_row        (mac_row)
    );

    sysarr_partial_adder u_add (
        .clk       (clk),
        .nRST      (nRST),
        .mac_valid (mac_valid),
        .add_start (ctrl.add_start),
        .mac_row   (mac_row),
        .ps_row    (ps_head),
        .sum_valid (sum_valid),
        .sum_row   (sum_row)
    );

    sysarr_row_fifo #(
        .payload_t (sysarr_pkg::acc_row_t),
        .DEPTH     (`SYSARR_FIFO_DEPTH)
    ) u_out_fifo (
        .clk       (clk),
        .nRST      (nRST),
        .push      (sum_valid),
        .push_data (sum_row),
        .pop       (!out_empty), // no back-pressure, every row leaves at once
        .pop_data  (out_row),
        .empty     (out_empty),
        .full      ()
    );

    assign out_valid = !out_empty;

endmodule

//--- verif/sysarr_tb_util.svh
`ifndef SYSARR_TB_UTIL_SVH
`define SYSARR_TB_UTIL_SVH

// one step of a 32-bit Galois LFSR shifting right, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
        nxt = nxt ^ 32'h80200003;
    end
    return nxt;
endfunction

// n random bits, the generator advances once for every bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_step(lfsr);
        r = {r[30:0], lfsr[0]};
    end
    return r;
endfunction

function automatic int rand_gap(input int max_gap);
    int gap;
    gap = 0;
    if (max_gap > 0) begin
        gap = int'(rand_bits(3)) % (max_gap + 1);
    end
    return gap;
endfunction

function automatic sysarr_pkg::data_row_t rand_data_row();
    sysarr_pkg::data_row_t r;
    for (int k = 0; k < N; k++) begin
        r[k] = sysarr_pkg::data_t'(rand_bits(`SYSARR_DATA_W));
    end
    return r;
endfunction

function automatic sysarr_pkg::acc_row_t rand_acc_row();
    sysarr_pkg::acc_row_t r;
    for (int c = 0; c < N; c++) begin
        r[c] = sysarr_pkg::acc_t'(rand_bits(`SYSARR_ACC_W));
    end
    return r;
endfunction

// out[c] = ps[c] + sum over k of x[k] * w[k][c], kept to the accumulator width
function automatic sysarr_pkg::acc_row_t model_row(
    input sysarr_pkg::data_row_t x,
    input sysarr_pkg::data_row_t w [N],
    input sysarr_pkg::acc_row_t ps
);
    sysarr_pkg::acc_row_t r;
    int acc;
    for (int c = 0; c < N; c++) begin
        acc = int'(ps[c]);
        for (int k = 0; k < N; k++) begin
            acc += int'(x[k]) * int'(w[k][c]);
        end
        r[c] = acc[`SYSARR_ACC_W-1:0]; // wraps like the hardware
    end
    return r;
endfunction

// sign-extended copy, what an identity matrix with zero partials gives back
function automatic sysarr_pkg::acc_row_t widen_row(input sysarr_pkg::data_row_t x);
    sysarr_pkg::acc_row_t r;
    for (int k = 0; k < N; k++) begin
        r[k] = sysarr_pkg::acc_t'(x[k]);
    end
    return r;
endfunction

task automatic check_row(
    input string name,
    input sysarr_pkg::acc_row_t expected,
    input sysarr_pkg::acc_row_t actual
);
    if (actual !== expected) begin
        $display("CHECK FAILED at %0t ns: %s expected %h, actual %h",
                 $time, name, expected, actual);
        stop_run();
    end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("CHECK FAILED at %0t ns: %s expected %b, actual %b",
                 $time, name, expected, actual);
        stop_run();
    end
endtask

`endif

//--- verif/sysarr_tb.sv
`include "sysarr_settings.svh"

module sysarr_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N = `SYSARR_N;
    localparam logic [31:0] SEED = 32'h3f9f;
    localparam int RANDOM_JOBS = 12;
    localparam int SPACE_TIMEOUT = 400; // cycles
    localparam int IDLE_TIMEOUT = 1000;
    localparam int DRAIN_CYCLES = 3 * N;

    logic clk;
    logic nRST;
    sysarr_pkg::load_t load;
    sysarr_pkg::ps_load_t ps_load;
    logic fifo_has_space;
    logic out_valid;
    sysarr_pkg::acc_row_t out_row;

    logic [31:0] lfsr;
    sysarr_pkg::data_row_t cur_w [N]; // weights the DUT holds right now
    sysarr_pkg::acc_row_t exp_q [$];  // expected result rows in job order

    sysarr_top DUT (
        .clk            (clk),
        .nRST           (nRST),
        .load           (load),
        .ps_load        (ps_load),
        .fifo_has_space (fifo_has_space),
        .out_valid      (out_valid),
        .out_row        (out_row)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    `include "sysarr_tb_util.svh"

    task automatic wait_space();
        int cycles;
        cycles = 0;
        while (!fifo_has_space && cycles < SPACE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!fifo_has_space) begin
            report_failure("fifo_has_space never came back high for the next job");
        end
    endtask

    // all expected rows are out and no slot collects rows any more
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while ((exp_q.size() != 0 || !fifo_has_space) && cycles < IDLE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            report_failure($sformatf("%0d result rows never came out", exp_q.size()));
        end else if (!fifo_has_space) begin
            report_failure("the DUT did not go idle after the last job");
        end
    endtask

    task automatic load_weights(input sysarr_pkg::data_row_t w [N]);
        wait_idle();
        for (int k = 0; k < N; k++) begin
            load = '0;
            load.weight_en = 1'b1;
            load.row = sysarr_pkg::row_idx_t'(k);
            load.data = w[k];
            cur_w[k] = w[k];
            @(negedge clk);
        end
        load = '0;
    endtask

    // input and partial rows of one job, each stream with its own gaps
    task automatic send_job(
        input sysarr_pkg::data_row_t in_rows [N],
        input sysarr_pkg::acc_row_t ps_rows [N],
        input int max_gap,
        input int ps_lag
    );
        int in_i;
        int ps_i;
        int in_wait;
        int ps_wait;
        in_i = 0;
        ps_i = 0;
        in_wait = 0;
        ps_wait = ps_lag;
        wait_space();
        while (in_i < N || ps_i < N) begin
            load = '0;
            ps_load = '0;
            if (in_i < N && in_wait == 0) begin
                load.input_en = 1'b1;
                load.row = sysarr_pkg::row_idx_t'(in_i);
                load.data = in_rows[in_i];
                in_i++;
                in_wait = rand_gap(max_gap);
            end else if (in_wait > 0) begin
                in_wait--;
            end
            if (ps_i < N && ps_wait == 0) begin
                ps_load.partial_en = 1'b1;
                ps_load.row = sysarr_pkg::row_idx_t'(ps_i);
                ps_load.data = ps_rows[ps_i];
                ps_i++;
                ps_wait = rand_gap(max_gap);
            end else if (ps_wait > 0) begin
                ps_wait--;
            end
            @(negedge clk);
        end
        load = '0;
        ps_load = '0;
    endtask

    task automatic run_random_job(input int max_gap, input int max_lag);
        sysarr_pkg::data_row_t in_rows [N];
        sysarr_pkg::acc_row_t ps_rows [N];
        int lag;
        for (int r = 0; r < N; r++) begin
            in_rows[r] = rand_data_row();
            ps_rows[r] = rand_acc_row();
            exp_q.push_back(model_row(in_rows[r], cur_w, ps_rows[r]));
        end
        lag = (max_lag == 0) ? 0 : N + rand_gap(max_lag); // partials trail the inputs
        send_job(in_rows, ps_rows, max_gap, lag);
    endtask

    // each result row is valid for one cycle only
    always @(negedge clk) begin
        if (nRST && out_valid) begin
            if (exp_q.size() == 0) begin
                report_failure("out_valid came while no result row was expected");
            end else begin
                check_row("out_row", exp_q.pop_front(), out_row);
            end
        end
    end

    initial begin
        sysarr_pkg::data_row_t w [N];
        sysarr_pkg::data_row_t in_rows [N];
        sysarr_pkg::acc_row_t ps_rows [N];
        load = '0;
        ps_load = '0;
        nRST = 1'b0;
        lfsr = SEED;
        repeat (16) @(posedge clk);
        @(negedge clk);
        nRST = 1'b1;
        @(negedge clk);
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("fifo_has_space", 1'b1, fifo_has_space);

        for (int k = 0; k < N; k++) begin
            w[k] = '0;
            w[k][k] = 8'sd1;
        end
        load_weights(w);
        for (int r = 0; r < N; r++) begin
            in_rows[r] = rand_data_row();
            ps_rows[r] = '0;
            exp_q.push_back(widen_row(in_rows[r]));
        end
        send_job(in_rows, ps_rows, 0, 0);
        wait_idle();

        for (int k = 0; k < N; k++) begin
            w[k] = rand_data_row();
        end
        load_weights(w);
        repeat (RANDOM_JOBS) run_random_job(0, 0); // loaded as soon as there is space
        repeat (6) run_random_job(3, 2 * N);

        // new weights between jobs, later rows follow them
        for (int k = 0; k < N; k++) begin
            w[k] = rand_data_row();
        end
        load_weights(w);
        repeat (8) run_random_job(0, 0);
        wait_idle();

        // any result row beyond N per job would still show up in this window
        repeat (DRAIN_CYCLES) @(negedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

//--- sysarr.f
+incdir+source
+incdir+verif
source/sysarr_pkg.sv
source/sysarr_row_fifo.sv
source/sysarr_mac_array.sv
source/sysarr_partial_adder.sv
source/sysarr_control_unit.sv
source/sysarr_top.sv
verif/sysarr_tb.sv

//--- Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
TOP        := sysarr_tb
FILELIST   := sysarr.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
